//--- bench/cart_loader_tb.sv
// Testbench for the cartridge load controller
// Host downloads, a memory responder with random ack delay, run limit
`timescale 1ns/1ps
`include "cart_loader_params.svh"

module cart_loader_tb;
	import cart_loader_pkg::*;

	localparam int HDR_WORDS = (`HDR_DONE / 2) + 1;
	localparam int CART_RUNS = 6;
	localparam int MAX_HS = 12; // Beat, request, ack wait up to 5, release
	localparam int CYCLE_LIMIT = CART_RUNS * HDR_WORDS * MAX_HS + 500;

	logic clk_sys;
	logic RESET;
	ioctl_beat_t beat;
	logic download;
	logic [7:0] index;
	region_cfg_t region_cfg;
	logic mem_ack = 1'b0;
	logic wait_host;
	logic mem_req;
	logic [`CART_ADDR_W-2:0] mem_addr;
	logic [`CART_DATA_W-1:0] mem_data;
	logic [`CART_ADDR_W-1:0] rom_size;
	region_t region_req;
	logic region_set;
	cart_quirks_t quirks;
	cheat_code_t cheat_code;
	logic cheat_valid;
	logic cheat_reset;

	region_t exp_region;
	logic exp_set;
	cart_quirks_t exp_quirks;
	cheat_code_t exp_cheat;
	logic check_failed;
	logic [31:0] stim_seed = 32'd22;
	logic [31:0] resp_seed = 32'd22;
	logic resp_busy;
	logic [2:0] resp_cnt;
	int cycles;

	cart_loader u_cart_loader (.*);

	cart_loader_tb_checks u_checks (.*, .failed(check_failed));

	always #4 clk_sys = ~clk_sys;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// Memory side, acks each request after 0 to 5 cycles
	always @(posedge clk_sys) begin
		if (RESET) begin
			mem_ack <= 1'b0;
			resp_busy <= 1'b0;
		end else if (!resp_busy && mem_req != mem_ack) begin
			resp_seed = lcg_next(resp_seed);
			resp_cnt <= 3'(resp_seed[18:16] % 6);
			resp_busy <= 1'b1;
		end else if (resp_busy) begin
			if (resp_cnt == 0) begin
				mem_ack <= mem_req;
				resp_busy <= 1'b0;
			end else begin
				resp_cnt <= resp_cnt - 3'd1;
			end
		end
	end

	// Stop at the first failed check or when the run limit is hit
	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (check_failed) begin
			$display("Test failures found");
			$fatal(1, "Stopped at the first failed check");
		end else if (cycles >= CYCLE_LIMIT) begin
			$display("Run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Test failures found");
			$fatal(1, "Timeout");
		end
	end

	// Called on a rising edge, returns on one with the host free
	task automatic send_word(input logic [`CART_ADDR_W-1:0] a, input logic [15:0] d);
		beat <= '{wr: 1'b1, addr: a, data: d};
		@(posedge clk_sys);
		beat.wr <= 1'b0;
		do @(posedge clk_sys); while (wait_host);
	endtask

	task automatic cart_download(input region_cfg_t cfg, input logic [7:0] idx,
		input logic [23:0] rgn, input logic [63:0] serial);
		logic [7:0] img [0:`HDR_DONE+1];
		int a;
		for (a = 0; a <= `HDR_DONE + 1; a++) begin
			stim_seed = lcg_next(stim_seed);
			img[a] = stim_seed[23:16];
		end
		for (a = 0; a < 8; a++)
			img[`HDR_ID_FIRST + 1 + a] = serial[63 - 8 * a -: 8]; // Serial from odd byte
		img[`HDR_REGION0] = rgn[23:16];
		img[`HDR_REGION0 + 1] = rgn[15:8];
		img[`HDR_REGION1] = rgn[7:0];
		region_cfg <= cfg;
		index <= idx;
		download <= 1'b1;
		@(posedge clk_sys);
		for (a = 0; a <= `HDR_DONE; a += 2)
			send_word(25'(a), {img[a + 1], img[a]});
		download <= 1'b0;
		repeat (4) @(posedge clk_sys);
	endtask

	task automatic cheat_download();
		logic [15:0] cw [0:7];
		int i;
		for (i = 0; i < 8; i++) begin
			stim_seed = lcg_next(stim_seed);
			cw[i] = stim_seed[31:16];
		end
		exp_cheat <= '{flags: {cw[1], cw[0]}, address: {cw[3], cw[2]},
			compare: {cw[5], cw[4]}, replace: {cw[7], cw[6]}};
		index <= 8'hFF;
		download <= 1'b1;
		@(posedge clk_sys);
		for (i = 0; i < 8; i++)
			send_word(25'(2 * i), cw[i]);
		download <= 1'b0;
		repeat (4) @(posedge clk_sys);
	endtask

	initial begin
		clk_sys = 1'b0;
		RESET = 1'b1;
		beat = '0;
		download = 1'b0;
		index = 8'h00;
		region_cfg = '{mode: MODE_HEADER, prio: PRIO_US_EU_JP};
		exp_region = REGION_JP;
		exp_set = 1'b0;
		exp_quirks = '{gun_sensor_delay: 8'd44, default: '0};
		exp_cheat = '0;
		cycles = 0;
		repeat (2) @(posedge clk_sys);
		RESET <= 1'b0;
		@(posedge clk_sys);

		// Header mode
		exp_region <= REGION_EU;
		exp_set <= 1'b1;
		exp_quirks <= '{fifo: 1'b1, gun_sensor_delay: 8'd44, default: '0};
		cart_download('{mode: MODE_HEADER, prio: PRIO_EU_US_JP}, 8'h00, {"E", "U", " "},
			"T-89016 ");
		exp_region <= REGION_JP;
		exp_quirks <= '{gun_type: 1'b1, gun_sensor_delay: 8'd52, default: '0};
		cart_download('{mode: MODE_HEADER, prio: PRIO_JP_US_EU}, 8'h00, "   ", "T-95096-");
		exp_region <= REGION_US;
		exp_quirks <= '{gun_sensor_delay: 8'd44, default: '0};
		cart_download('{mode: MODE_HEADER, prio: PRIO_US_EU_JP}, 8'h00, "5  ", "ABCDEFGH");

		// File extension mode
		exp_region <= REGION_EU;
		cart_download('{mode: MODE_FILE_EXT, prio: PRIO_US_EU_JP}, 8'h80, "   ", "ABCDEFGH");
		exp_region <= REGION_US;
		cart_download('{mode: MODE_FILE_EXT, prio: PRIO_US_EU_JP}, 8'h40, "   ", "ABCDEFGH");
		exp_region <= REGION_JP;
		exp_set <= 1'b0;
		cart_download('{mode: MODE_FILE_EXT, prio: PRIO_US_EU_JP}, 8'h00, "   ", "ABCDEFGH");

		cheat_download();

		repeat (4) @(posedge clk_sys);
		if (check_failed) begin
			$display("Test failures found");
			$fatal(1, "Checks failed");
		end else begin
			$display("All tests passed!");
			$finish;
		end
	end

endmodule

//--- bench/cart_loader_tb_checks.sv
// Testbench checks for the cartridge load controller
// Concurrent assertions with small reference models of the expected outputs
`timescale 1ns/1ps
`include "cart_loader_params.svh"

module cart_loader_tb_checks (
	input logic clk_sys,
	input logic RESET,
	input cart_loader_pkg::ioctl_beat_t beat,
	input logic download,
	input logic [7:0] index,
	input logic mem_req,
	input logic mem_ack,
	input logic wait_host,
	input logic [`CART_ADDR_W-2:0] mem_addr,
	input logic [`CART_DATA_W-1:0] mem_data,
	input logic [`CART_ADDR_W-1:0] rom_size,
	input cart_loader_pkg::region_t region_req,
	input logic region_set,
	input cart_loader_pkg::cart_quirks_t quirks,
	input cart_loader_pkg::cheat_code_t cheat_code,
	input logic cheat_valid,
	input logic cheat_reset,
	input cart_loader_pkg::region_t exp_region,
	input logic exp_set,
	input cart_loader_pkg::cart_quirks_t exp_quirks,
	input cart_loader_pkg::cheat_code_t exp_cheat,
	output logic failed
);
	import cart_loader_pkg::*;

	localparam cart_quirks_t QUIRKS_NONE = '{
		gun_sensor_delay: 8'(`GUN_DELAY_DEFAULT),
		default: '0
	};

	logic cart_dl;
	logic cart_wr;
	logic code_wr;
	logic req_q;
	int beat_cnt;
	int toggle_cnt;
	logic [`CART_ADDR_W-1:0] last_addr;
	logic [`CART_ADDR_W-2:0] exp_addr; // Word address of the last beat
	logic [`CART_DATA_W-1:0] exp_data;

	assign cart_dl = download && (index != 8'hFF);
	assign cart_wr = beat.wr && cart_dl;
	assign code_wr = beat.wr && download && (index == 8'hFF);

	initial failed = 1'b0;

	//////////////////////////////
	// Reference models
	//////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			req_q <= 1'b0;
			beat_cnt <= 0;
			toggle_cnt <= 0;
		end else begin
			req_q <= mem_req;
			if (mem_req != req_q) toggle_cnt <= toggle_cnt + 1;
			if (cart_wr) begin
				beat_cnt <= beat_cnt + 1;
				last_addr <= beat.addr;
				exp_addr <= beat.addr[`CART_ADDR_W-1:1]; // Drop the byte bit
				exp_data <= {beat.data[7:0], beat.data[15:8]};
			end
		end
	end

	a_reset_idle: assert property (@(posedge clk_sys) $fell(RESET) |->
		!wait_host && !mem_req && !region_set && !cheat_valid && !cheat_reset &&
		quirks == QUIRKS_NONE)
		else begin
			$display("Error after reset wait_host=%h mem_req=%h quirks=%h", wait_host, mem_req,
				quirks);
			failed = 1'b1;
		end

	//////////////////////////////
	// Memory handshake
	//////////////////////////////
	a_req_per_beat: assert property (@(posedge clk_sys) disable iff (RESET)
		cart_wr |=> wait_host && mem_req != req_q && mem_addr == exp_addr &&
		mem_data == exp_data)
		else begin
			$display("Error wait_host=%h mem_addr=%h expected %h mem_data=%h expected %h",
				wait_host, mem_addr, exp_addr, mem_data, exp_data);
			failed = 1'b1;
		end

	a_one_toggle: assert property (@(posedge clk_sys) disable iff (RESET)
		$fell(cart_dl) |-> toggle_cnt == beat_cnt)
		else begin
			$display("Error mem_req toggles=%h expected %h", toggle_cnt, beat_cnt);
			failed = 1'b1;
		end

	a_wait_release: assert property (@(posedge clk_sys) disable iff (RESET)
		$fell(wait_host) |-> $past(mem_req == mem_ack))
		else begin
			$display("wait_host fell before memory acknowledged the write");
			failed = 1'b1;
		end

	a_rom_size: assert property (@(posedge clk_sys) disable iff (RESET)
		$fell(cart_dl) |=> rom_size == last_addr)
		else begin
			$display("Error rom_size=%h expected %h", rom_size, last_addr);
			failed = 1'b1;
		end

	//////////////////////////////
	// Region
	//////////////////////////////
	a_region: assert property (@(posedge clk_sys) disable iff (RESET)
		cart_wr && beat.addr == `HDR_DONE |=> ##1
		region_req == exp_region && region_set == exp_set)
		else begin
			$display("Error region_req=%h expected %h region_set=%h expected %h", region_req,
				exp_region, region_set, exp_set);
			failed = 1'b1;
		end

	a_region_clear: assert property (@(posedge clk_sys) disable iff (RESET)
		$fell(cart_dl) |=> ##1 !region_set)
		else begin
			$display("Error region_set=%h expected 0", region_set);
			failed = 1'b1;
		end

	//////////////////////////////
	// Quirks and cheats
	//////////////////////////////
	a_quirk_lookup: assert property (@(posedge clk_sys) disable iff (RESET)
		cart_wr && beat.addr == `HDR_ID_LAST |=> quirks == exp_quirks)
		else begin
			$display("Error quirks=%h expected %h", quirks, exp_quirks);
			failed = 1'b1;
		end

	a_quirk_restore: assert property (@(posedge clk_sys) disable iff (RESET)
		$rose(cart_dl) |=> quirks == QUIRKS_NONE)
		else begin
			$display("Error quirks=%h expected %h", quirks, QUIRKS_NONE);
			failed = 1'b1;
		end

	a_cheat_code: assert property (@(posedge clk_sys) disable iff (RESET)
		code_wr && beat.addr[3:0] == 4'd14 |=> cheat_valid && cheat_code == exp_cheat)
		else begin
			$display("Error cheat_code=%h expected %h cheat_valid=%h", cheat_code, exp_cheat,
				cheat_valid);
			failed = 1'b1;
		end

	a_cheat_pulse: assert property (@(posedge clk_sys) disable iff (RESET)
		cheat_valid |-> $past(code_wr && beat.addr[3:0] == 4'd14))
		else begin
			$display("cheat_valid pulsed without the last word of a record");
			failed = 1'b1;
		end

	a_cheat_reset: assert property (@(posedge clk_sys) disable iff (RESET)
		code_wr && beat.addr == '0 |=> cheat_reset)
		else begin
			$display("Error cheat_reset=%h expected 1", cheat_reset);
			failed = 1'b1;
		end

	a_cheat_reset_pulse: assert property (@(posedge clk_sys) disable iff (RESET)
		cheat_reset |-> $past(code_wr && beat.addr == '0))
		else begin
			$display("cheat_reset pulsed without a cheat word at address 0");
			failed = 1'b1;
		end

endmodule

//--- cart_loader.f
+incdir+verilog
verilog/cart_loader_pkg.sv
verilog/rom_write_pacer.sv
verilog/header_region_scan.sv
verilog/region_select.sv
verilog/cart_id_quirks.sv
verilog/cheat_code_loader.sv
verilog/cart_loader.sv
bench/cart_loader_tb_checks.sv
bench/cart_loader_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the cartridge loader testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f cart_loader.f \
	--top-module cart_loader_tb -o sim_cart_loader &&
	./obj_dir/sim_cart_loader | tee /dev/stderr | grep -q "All tests passed!" &&
	echo "Simulation PASSED" ||
	{ echo "Simulation FAILED"; exit 1; }

//--- verilog/cart_id_quirks.sv
// Product serial capture and quirk lookup
// Serial from the header is matched against known titles
`timescale 1ns/1ps
`include "cart_loader_params.svh"

module cart_id_quirks (
	input logic clk_sys,
	input logic RESET,
	input cart_loader_pkg::ioctl_beat_t beat,
	input logic cart_dl,
	output cart_loader_pkg::cart_quirks_t quirks
);
	import cart_loader_pkg::*;

	localparam cart_quirks_t QUIRKS_IDLE = '{
		gun_sensor_delay: 8'(`GUN_DELAY_DEFAULT),
		default: '0
	};

	logic old_dl;
	logic [63:0] cart_id; // Eight ASCII characters
	logic [15:0] swapped;
	cart_quirks_t found;

	assign swapped = {beat.data[7:0], beat.data[15:8]};

	// Serial words, first and last are half used
	always_ff @(posedge clk_sys) begin
		if (beat.wr) begin
			if (beat.addr == `HDR_ID_FIRST) cart_id[63:56] <= beat.data[15:8];
			if (beat.addr == (`HDR_ID_FIRST + 2)) cart_id[55:40] <= swapped;
			if (beat.addr == (`HDR_ID_FIRST + 4)) cart_id[39:24] <= swapped;
			if (beat.addr == (`HDR_ID_FIRST + 6)) cart_id[23:8] <= swapped;
			if (beat.addr == (`HDR_ID_FIRST + 8)) cart_id[7:0] <= beat.data[7:0];
		end
	end

	//////////////////////////////
	// Serial table
	//////////////////////////////
	always_comb begin
		found = QUIRKS_IDLE;
		case (cart_id)
			"T-081276", "T-81406 ", "T-081586", "T-81576 ", "T-81476 ":
				found.sram = 1'b1; // SRAM mapped without header entry
			"MK-1215 ", "G-4060  ", "00001211", "MK-1228 ", "G-5538  ",
			"00004076", "T-12046 ", "T-12053 ", "G-4524  ":
				found.eeprom = 1'b1; // Serial EEPROM saves
			"T-113016": found.noram = 1'b1; // Fake RAM check
			"T-89016 ": found.fifo = 1'b1;
			"T-574023", "T-574013": found.pier = 1'b1;
			"MK-1229 ", "G-7001  ": found.svp = 1'b1; // SVP coprocessor carts
			"T-35036 ", "T-25073 ", "MK-1137-": found.fmbusy = 1'b1;
			"T-68???-": found.schan = 1'b1;
			" GM 0000": found.sram00 = 1'b1;

			// Light-gun titles
			"MK-1533 ": found.gun_sensor_delay = 8'd100;
			"T-95096-": begin
				found.gun_type = 1'b1;
				found.gun_sensor_delay = 8'd52;
			end
			"T-95136-": begin
				found.gun_type = 1'b1;
				found.gun_sensor_delay = 8'd30;
			end
			"MK-1658 ": found.gun_sensor_delay = 8'd120;
			"T-081156": found.gun_sensor_delay = 8'd126;
			default: ;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			quirks <= QUIRKS_IDLE;
			old_dl <= 1'b0;
		end else begin
			old_dl <= cart_dl;
			if (!old_dl && cart_dl)
				quirks <= QUIRKS_IDLE; // Forget previous cartridge
			else if (beat.wr && beat.addr == `HDR_ID_LAST)
				quirks <= found;
		end
	end

endmodule

//--- verilog/cart_loader.sv
// Cartridge load controller top
// Splits the host download into cartridge and cheat streams
`timescale 1ns/1ps
`include "cart_loader_params.svh"

module cart_loader (
	input logic clk_sys,
	input logic RESET,
	input cart_loader_pkg::ioctl_beat_t beat,
	input logic download,
	input logic [7:0] index,
	input cart_loader_pkg::region_cfg_t region_cfg,
	input logic mem_ack,
	output logic wait_host,
	output logic mem_req,
	output logic [`CART_ADDR_W-2:0] mem_addr,
	output logic [`CART_DATA_W-1:0] mem_data,
	output logic [`CART_ADDR_W-1:0] rom_size,
	output cart_loader_pkg::region_t region_req,
	output logic region_set,
	output cart_loader_pkg::cart_quirks_t quirks,
	output cart_loader_pkg::cheat_code_t cheat_code,
	output logic cheat_valid,
	output logic cheat_reset
);
	import cart_loader_pkg::*;

	logic code_index;
	logic cart_dl;
	logic code_dl;
	ioctl_beat_t cart_beat;
	ioctl_beat_t code_beat;
	hdr_flags_t hdr_flags;
	logic hdr_ready;

	assign code_index = &index; // All ones is a cheat file
	assign cart_dl = download & ~code_index;
	assign code_dl = download & code_index;

	// Write strobe qualified per download kind
	always_comb begin
		cart_beat = beat;
		cart_beat.wr = beat.wr & cart_dl;
		code_beat = beat;
		code_beat.wr = beat.wr & code_dl;
	end

	rom_write_pacer u_rom_write_pacer (
		.clk_sys(clk_sys), .RESET(RESET), .beat(cart_beat), .cart_dl(cart_dl),
		.mem_ack(mem_ack), .wait_host(wait_host), .mem_req(mem_req),
		.mem_addr(mem_addr), .mem_data(mem_data), .rom_size(rom_size)
	);

	header_region_scan u_header_region_scan (
		.clk_sys(clk_sys), .RESET(RESET), .beat(cart_beat), .cart_dl(cart_dl),
		.flags(hdr_flags), .hdr_ready(hdr_ready)
	);

	region_select u_region_select (
		.clk_sys(clk_sys), .RESET(RESET), .flags(hdr_flags), .hdr_ready(hdr_ready),
		.region_cfg(region_cfg), .index(index),
		.region_req(region_req), .region_set(region_set)
	);

	cart_id_quirks u_cart_id_quirks (
		.clk_sys(clk_sys), .RESET(RESET), .beat(cart_beat), .cart_dl(cart_dl),
		.quirks(quirks)
	);

	cheat_code_loader u_cheat_code_loader (
		.clk_sys(clk_sys), .RESET(RESET), .beat(code_beat), .code_dl(code_dl),
		.cheat_code(cheat_code), .cheat_valid(cheat_valid), .cheat_reset(cheat_reset)
	);

endmodule

//--- verilog/cart_loader_params.svh
// Cartridge load controller constants
// Beat widths, header offsets, cheat record size, light-gun default
`ifndef CART_LOADER_PARAMS_SVH
`define CART_LOADER_PARAMS_SVH

//////////////////////////////
// Host download beat
//////////////////////////////
`define CART_ADDR_W 25 // Byte address
`define CART_DATA_W 16 // One word per beat

//////////////////////////////
// Cartridge header offsets
//////////////////////////////
// Product serial spans these words
`define HDR_ID_FIRST 'h182
`define HDR_ID_LAST 'h18C // Serial lookup fires here

// Region letters or hex digit
`define HDR_REGION0 'h1F0
`define HDR_REGION1 'h1F2

`define HDR_DONE 'h200 // First word past the header

//////////////////////////////
// Cheats and light gun
//////////////////////////////
`define CHEAT_REC_BYTES 16 // Four 32-bit fields
`define GUN_DELAY_DEFAULT 44

`endif

//--- verilog/cart_loader_pkg.sv
// Types shared across the cartridge load controller
// Host beat, region selection, quirk set and cheat record
`include "cart_loader_params.svh"

package cart_loader_pkg;

	// One host write beat
	typedef struct packed {
		logic wr;
		logic [`CART_ADDR_W-1:0] addr;
		logic [`CART_DATA_W-1:0] data;
	} ioctl_beat_t;

	typedef enum logic [1:0] {
		REGION_JP = 2'd0,
		REGION_US = 2'd1,
		REGION_EU = 2'd2
	} region_t;

	typedef enum logic [1:0] {
		MODE_HEADER = 2'd0, // Scan cartridge header
		MODE_FILE_EXT = 2'd1, // Region from download index
		MODE_DISABLED = 2'd2
	} region_mode_t;

	// Search order when several flags are set
	typedef enum logic [1:0] {
		PRIO_US_EU_JP = 2'd0,
		PRIO_EU_US_JP = 2'd1,
		PRIO_US_JP_EU = 2'd2,
		PRIO_JP_US_EU = 2'd3
	} region_prio_t;

	typedef struct packed {
		region_mode_t mode;
		region_prio_t prio;
	} region_cfg_t;

	typedef struct packed {
		logic j;
		logic u;
		logic e;
	} hdr_flags_t;

	typedef struct packed {
		logic sram;
		logic sram00;
		logic eeprom;
		logic fifo;
		logic noram;
		logic pier;
		logic svp;
		logic fmbusy;
		logic schan;
		logic gun_type; // 1 selects the Justifier style gun
		logic [7:0] gun_sensor_delay;
	} cart_quirks_t;

	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

endpackage

//--- verilog/cheat_code_loader.sv
// Cheat record loader
// Builds 16-byte records from word writes and strobes each code out
`timescale 1ns/1ps
`include "cart_loader_params.svh"

module cheat_code_loader (
	input logic clk_sys,
	input logic RESET,
	input cart_loader_pkg::ioctl_beat_t beat,
	input logic code_dl,
	output cart_loader_pkg::cheat_code_t cheat_code,
	output logic cheat_valid,
	output logic cheat_reset
);

	localparam int OFF_W = $clog2(`CHEAT_REC_BYTES);

	logic wr_en;
	logic [OFF_W-1:0] off; // Byte offset inside the record
	logic [6:0] lsb;

	assign wr_en = beat.wr & code_dl;
	assign off = beat.addr[OFF_W-1:0];
	// Field 0 sits on top, low word first
	assign lsb = {~off[3:2], off[1], 4'd0};

	always_ff @(posedge clk_sys) begin
		if (wr_en && !off[0])
			cheat_code[lsb +: 16] <= beat.data;
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cheat_valid <= 1'b0;
			cheat_reset <= 1'b0;
		end else begin
			cheat_valid <= wr_en && (off == OFF_W'(`CHEAT_REC_BYTES - 2)); // Replace top word
			cheat_reset <= wr_en && (beat.addr == '0); // New cheat file
		end
	end

endmodule

//--- verilog/header_region_scan.sv
// Cartridge header region scan
// Collects J/U/E flags from the region field, flags header end
`timescale 1ns/1ps
`include "cart_loader_params.svh"

module header_region_scan (
	input logic clk_sys,
	input logic RESET,
	input cart_loader_pkg::ioctl_beat_t beat,
	input logic cart_dl,
	output cart_loader_pkg::hdr_flags_t flags,
	output logic hdr_ready
);
	import cart_loader_pkg::*;

	logic old_dl;
	logic [7:0] lo;
	logic [7:0] hi;
	logic [3:0] hrgn;
	logic lo_letter;
	hdr_flags_t flags_nxt;

	// Set the flag named by a letter, others untouched
	function automatic hdr_flags_t mark_letter(input hdr_flags_t f, input logic [7:0] c);
		hdr_flags_t r;
		r = f;
		case (c)
			"J": r.j = 1'b1;
			"U": r.u = 1'b1;
			"E": r.e = 1'b1;
			default: ;
		endcase
		return r;
	endfunction

	assign lo = beat.data[7:0];
	assign hi = beat.data[15:8];
	assign hrgn = lo[3:0] - 4'd7; // 'A'..'F' to 10..15
	assign lo_letter = lo inside {"J", "U", "E"};

	always_comb begin
		flags_nxt = flags;
		if (beat.wr && beat.addr == `HDR_REGION0) begin
			if (lo_letter)
				flags_nxt = mark_letter(flags_nxt, lo);
			else if (lo >= "0" && lo <= "9")
				flags_nxt = '{j: lo[0], u: lo[2], e: lo[3]}; // Hex region digit
			else if (lo >= "A" && lo <= "F")
				flags_nxt = '{j: hrgn[0], u: hrgn[2], e: hrgn[3]};
			flags_nxt = mark_letter(flags_nxt, hi);
		end else if (beat.wr && beat.addr == `HDR_REGION1) begin
			flags_nxt = mark_letter(flags_nxt, lo);
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			flags <= '0;
			hdr_ready <= 1'b0;
			old_dl <= 1'b0;
		end else begin
			old_dl <= cart_dl;
			if (!old_dl && cart_dl) flags <= '0; // New cartridge
			else flags <= flags_nxt;
			if (old_dl && !cart_dl) hdr_ready <= 1'b0;
			else if (beat.wr && beat.addr == `HDR_DONE) hdr_ready <= 1'b1;
		end
	end

endmodule

//--- verilog/region_select.sv
// Region selection
// Picks the console region from header flags or the download index
`timescale 1ns/1ps

module region_select (
	input logic clk_sys,
	input logic RESET,
	input cart_loader_pkg::hdr_flags_t flags,
	input logic hdr_ready,
	input cart_loader_pkg::region_cfg_t region_cfg,
	input logic [7:0] index,
	output cart_loader_pkg::region_t region_req,
	output logic region_set
);
	import cart_loader_pkg::*;

	logic old_ready;
	region_t pick;

	// First flagged region in order, else the order's head
	always_comb begin
		case (region_cfg.prio)
			PRIO_US_EU_JP:
				pick = flags.u ? REGION_US : flags.e ? REGION_EU :
					flags.j ? REGION_JP : REGION_US;
			PRIO_EU_US_JP:
				pick = flags.e ? REGION_EU : flags.u ? REGION_US :
					flags.j ? REGION_JP : REGION_EU;
			PRIO_US_JP_EU:
				pick = flags.u ? REGION_US : flags.j ? REGION_JP :
					flags.e ? REGION_EU : REGION_US;
			default:
				pick = flags.j ? REGION_JP : flags.u ? REGION_US :
					flags.e ? REGION_EU : REGION_JP;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			region_req <= REGION_JP;
			region_set <= 1'b0;
			old_ready <= 1'b0;
		end else begin
			old_ready <= hdr_ready;
			if (!old_ready && hdr_ready) begin
				case (region_cfg.mode)
					MODE_HEADER: begin
						region_req <= pick;
						region_set <= 1'b1;
					end
					MODE_FILE_EXT: begin
						region_req <= region_t'(index[7:6]);
						region_set <= |index; // Plain file keeps current region
					end
					default: ; // Auto region off
				endcase
			end
			if (old_ready && !hdr_ready) region_set <= 1'b0;
		end
	end

	a_set_with_ready: assert property (@(posedge clk_sys) disable iff (RESET)
		$rose(region_set) |-> hdr_ready)
		else $error("Error region_set=%h hdr_ready=%h", region_set, hdr_ready);

endmodule

//--- verilog/rom_write_pacer.sv
// ROM write pacer
// One toggle request per cartridge beat, host held off until memory acks
`timescale 1ns/1ps
`include "cart_loader_params.svh"

module rom_write_pacer (
	input logic clk_sys,
	input logic RESET,
	input cart_loader_pkg::ioctl_beat_t beat,
	input logic cart_dl,
	input logic mem_ack,
	output logic wait_host,
	output logic mem_req,
	output logic [`CART_ADDR_W-2:0] mem_addr,
	output logic [`CART_DATA_W-1:0] mem_data,
	output logic [`CART_ADDR_W-1:0] rom_size
);

	logic old_dl;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			wait_host <= 1'b0;
			mem_req <= 1'b0;
			old_dl <= 1'b0;
		end else begin
			old_dl <= cart_dl;
			if (beat.wr) begin
				wait_host <= 1'b1;
				mem_req <= ~mem_req; // New request
			end else if (wait_host && (mem_req == mem_ack)) begin
				wait_host <= 1'b0;
			end
		end
	end

	// Write payload, word address and swapped bytes
	always_ff @(posedge clk_sys) begin
		if (beat.wr) begin
			mem_addr <= beat.addr[`CART_ADDR_W-1:1];
			mem_data <= {beat.data[7:0], beat.data[15:8]};
		end
		if (old_dl && !cart_dl)
			rom_size <= beat.addr; // Last address is the size
	end

	//////////////////////////////
	// Handshake checks
	//////////////////////////////
	a_no_beat_while_wait: assert property (@(posedge clk_sys) disable iff (RESET)
		wait_host |-> !beat.wr)
		else $error("Error beat.wr=%h wait_host=%h", beat.wr, wait_host);

	// A new request never replaces one still outstanding
	a_req_only_on_beat: assert property (@(posedge clk_sys) disable iff (RESET)
		$changed(mem_req) |-> $past(beat.wr && (mem_req == mem_ack)))
		else $error("Error mem_req=%h mem_ack=%h", mem_req, mem_ack);

endmodule
